/* cpu_cfg.svh */
// CPU configuration
// Reset fetch address, data width and register count of the
// five-stage integer core
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// First instruction fetched after reset
`define CPU_RESET_PC 32'h00003000

`define CPU_XLEN 32

`define CPU_NREGS 32

`endif

/* cpuPkg.sv */
// CPU package
// Shared word types, ALU selector, decoded control and the
// pipeline register layouts of the five-stage core
`include "cpu_cfg.svh"

package cpuPkg;

    typedef logic [`CPU_XLEN-1:0] word_t;
    typedef logic [4:0] regAddr_t;
    typedef logic [1:0] tnew_t;

    // ALU selector
    typedef logic [1:0] aluOp_t;
    localparam aluOp_t aluAdd = 2'd0;
    localparam aluOp_t aluSub = 2'd1;
    localparam aluOp_t aluOr  = 2'd2;
    localparam aluOp_t aluLui = 2'd3;

    typedef struct packed {
        aluOp_t   aluOp;
        logic     useImm;
        logic     zeroExt;
        logic     memRead;
        logic     memWrite;
        logic     byteStore;
        logic     regWrite;
        regAddr_t dest;
    } ctrl_t;

    typedef struct packed {
        word_t       pc;
        ctrl_t       ctrl;
        word_t       rsVal;
        regAddr_t    rsIdx;
        word_t       rtVal;
        regAddr_t    rtIdx;
        logic [15:0] imm16;
        tnew_t       tnew;
    } idEx_t;

    typedef struct packed {
        word_t    pc;
        ctrl_t    ctrl;
        word_t    aluOut;
        regAddr_t rtIdx;
        word_t    storeData;
        tnew_t    tnew;
    } exMem_t;

    typedef struct packed {
        word_t    pc;
        logic     regWrite;
        regAddr_t dest;
        word_t    result;
        logic     fromLoad;
    } memWb_t;

    // Newest ready value wins, memory stage before writeback
    function automatic word_t forwardValue(regAddr_t src, word_t base,
                                           exMem_t m, memWb_t w);
        word_t value;
        value = base;
        if (src != '0 && w.regWrite && w.dest == src) begin
            value = w.result;
        end
        if (src != '0 && m.tnew == '0 && m.ctrl.regWrite && m.ctrl.dest == src) begin
            value = m.aluOut;
        end
        return value;
    endfunction

endpackage

/* fetchStage.sv */
// Fetch stage
// Program counter with sequential or branch next-PC selection and
// the fetch/decode pipeline register, both frozen on a stall
`include "cpu_cfg.svh"

module fetchStage import cpuPkg::*; (
    input  logic  clk,
    input  logic  arstN,
    input  word_t instr,
    input  logic  stallFetch,
    input  logic  branchTaken,
    input  word_t branchTarget,
    output word_t instrAddr,
    output word_t fetchedInstr,
    output word_t fetchedPc
);

    word_t pc;
    word_t nextPc;

    // Delay slot is already being fetched when the branch resolves
    always_comb begin
        nextPc = branchTaken ? branchTarget : pc + 32'd4;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc           <= `CPU_RESET_PC;
            fetchedInstr <= '0;
            fetchedPc    <= '0;
        end else if (!stallFetch) begin
            pc           <= nextPc;
            fetchedInstr <= instr;
            fetchedPc    <= pc;
        end
    end

    assign instrAddr = pc;

endmodule

/* decodeStage.sv */
// Decode stage
// Instruction decode, register read with forwarding, beq compare
// and Tuse/Tnew reporting, feeding the decode/execute register
module decodeStage import cpuPkg::*; (
    input  logic     clk,
    input  logic     arstN,
    input  word_t    fetchedInstr,
    input  word_t    fetchedPc,
    input  logic     bubbleExecute,
    input  word_t    rdata1,
    input  word_t    rdata2,
    input  exMem_t   exMem,
    input  memWb_t   memWb,
    output regAddr_t raddr1,
    output regAddr_t raddr2,
    output regAddr_t rsIdx,
    output regAddr_t rtIdx,
    output tnew_t    rsUse,
    output tnew_t    rtUse,
    output logic     branchTaken,
    output word_t    branchTarget,
    output idEx_t    idEx
);

    localparam logic [5:0] opSpecial = 6'b000000;
    localparam logic [5:0] opBeq     = 6'b000100;
    localparam logic [5:0] opOri     = 6'b001101;
    localparam logic [5:0] opLui     = 6'b001111;
    localparam logic [5:0] opLw      = 6'b100011;
    localparam logic [5:0] opSb      = 6'b101000;
    localparam logic [5:0] opSw      = 6'b101011;
    localparam logic [5:0] fnAddu    = 6'b100001;
    localparam logic [5:0] fnSubu    = 6'b100011;

    logic [5:0]  opcode;
    logic [5:0]  funct;
    regAddr_t    rs;
    regAddr_t    rt;
    regAddr_t    rd;
    logic [15:0] imm16;
    ctrl_t       ctrl;
    tnew_t       tnew;
    logic        isBeq;
    word_t       rsVal;
    word_t       rtVal;

    assign opcode = fetchedInstr[31:26];
    assign rs     = fetchedInstr[25:21];
    assign rt     = fetchedInstr[20:16];
    assign rd     = fetchedInstr[15:11];
    assign imm16  = fetchedInstr[15:0];
    assign funct  = fetchedInstr[5:0];

    // Tuse of 3 marks a source that is never read
    always_comb begin
        ctrl  = '0;
        tnew  = 2'd0;
        rsUse = 2'd3;
        rtUse = 2'd3;
        isBeq = 1'b0;
        case (opcode)
            opSpecial: begin
                if (funct == fnAddu || funct == fnSubu) begin
                    ctrl.aluOp    = (funct == fnSubu) ? aluSub : aluAdd;
                    ctrl.regWrite = 1'b1;
                    ctrl.dest     = rd;
                    tnew  = 2'd1;
                    rsUse = 2'd1;
                    rtUse = 2'd1;
                end
            end
            opOri: begin
                ctrl.aluOp    = aluOr;
                ctrl.useImm   = 1'b1;
                ctrl.zeroExt  = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.dest     = rt;
                tnew  = 2'd1;
                rsUse = 2'd1;
            end
            opLui: begin
                ctrl.aluOp    = aluLui;
                ctrl.useImm   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.dest     = rt;
                tnew = 2'd1;
            end
            opLw: begin
                ctrl.aluOp    = aluAdd;
                ctrl.useImm   = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.dest     = rt;
                tnew  = 2'd2;
                rsUse = 2'd1;
            end
            opSw, opSb: begin
                ctrl.aluOp     = aluAdd;
                ctrl.useImm    = 1'b1;
                ctrl.memWrite  = 1'b1;
                ctrl.byteStore = (opcode == opSb);
                rsUse = 2'd1;
                // Store data only needed in the memory stage
                rtUse = 2'd2;
            end
            opBeq: begin
                isBeq = 1'b1;
                rsUse = 2'd0;
                rtUse = 2'd0;
            end
            default: begin
            end
        endcase
    end

    assign raddr1 = rs;
    assign raddr2 = rt;
    assign rsIdx  = rs;
    assign rtIdx  = rt;

    assign rsVal = forwardValue(rs, rdata1, exMem, memWb);
    assign rtVal = forwardValue(rt, rdata2, exMem, memWb);

    // Operands are stale while stalled
    assign branchTaken  = isBeq && (rsVal == rtVal) && !bubbleExecute;
    assign branchTarget = fetchedPc + 32'd4 + {{14{imm16[15]}}, imm16, 2'b00};

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            idEx <= '0;
        end else if (bubbleExecute) begin
            idEx <= '0;
        end else begin
            idEx.pc    <= fetchedPc;
            idEx.ctrl  <= ctrl;
            idEx.rsVal <= rsVal;
            idEx.rsIdx <= rs;
            idEx.rtVal <= rtVal;
            idEx.rtIdx <= rt;
            idEx.imm16 <= imm16;
            idEx.tnew  <= tnew;
        end
    end

endmodule

/* regFile.sv */
// General register file
// Two combinational read ports and one write port, register 0
// reads as zero, same-cycle writes bypass to the readers
`include "cpu_cfg.svh"

module regFile import cpuPkg::*; (
    input  logic     clk,
    input  logic     arstN,
    input  regAddr_t raddr1,
    input  regAddr_t raddr2,
    input  logic     we,
    input  regAddr_t waddr,
    input  word_t    wdata,
    output word_t    rdata1,
    output word_t    rdata2
);

    word_t regs [`CPU_NREGS];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `CPU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // Write-through lets writeback and decode share a cycle
    assign rdata1 = (raddr1 == '0) ? '0 :
                    (we && waddr == raddr1) ? wdata : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 :
                    (we && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

/* executeStage.sv */
// Execute stage
// Operand forwarding from memory and writeback, immediate
// extension, the four-operation ALU and the execute/memory register
module executeStage import cpuPkg::*; (
    input  logic   clk,
    input  logic   arstN,
    input  idEx_t  idEx,
    input  memWb_t memWb,
    output exMem_t exMem
);

    word_t rsVal;
    word_t rtVal;
    word_t immExt;
    word_t opB;
    word_t aluOut;

    assign rsVal = forwardValue(idEx.rsIdx, idEx.rsVal, exMem, memWb);
    assign rtVal = forwardValue(idEx.rtIdx, idEx.rtVal, exMem, memWb);

    assign immExt = idEx.ctrl.zeroExt ? {16'b0, idEx.imm16} :
                                        {{16{idEx.imm16[15]}}, idEx.imm16};
    assign opB    = idEx.ctrl.useImm ? immExt : rtVal;

    always_comb begin
        case (idEx.ctrl.aluOp)
            aluAdd:  aluOut = rsVal + opB;
            aluSub:  aluOut = rsVal - opB;
            aluOr:   aluOut = rsVal | opB;
            default: aluOut = {idEx.imm16, 16'b0};
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exMem <= '0;
        end else begin
            exMem.pc        <= idEx.pc;
            exMem.ctrl      <= idEx.ctrl;
            exMem.aluOut    <= aluOut;
            exMem.rtIdx     <= idEx.rtIdx;
            exMem.storeData <= rtVal;
            // One stage closer to the result
            exMem.tnew      <= (idEx.tnew == '0) ? '0 : idEx.tnew - 2'd1;
        end
    end

endmodule

/* memStage.sv */
// Memory stage
// Drives the bridge bus with word or byte stores, captures load
// data and holds the memory/writeback register and its selection
module memStage import cpuPkg::*; (
    input  logic       clk,
    input  logic       arstN,
    input  exMem_t     exMem,
    input  word_t      BrRData,
    output word_t      BrPC,
    output word_t      BrAddr,
    output word_t      BrWData,
    output logic [3:0] BrWE,
    output memWb_t     memWb,
    output logic       regWe,
    output regAddr_t   regWAddr,
    output word_t      regWData
);

    memWb_t wbReg;
    word_t  loadWord;
    word_t  wbValue;
    word_t  storeData;
    logic [1:0] lane;

    // Late store data from a load just ahead
    assign storeData = (wbReg.regWrite && wbReg.dest != '0 && wbReg.dest == exMem.rtIdx) ?
                       wbValue : exMem.storeData;

    assign lane    = exMem.aluOut[1:0];
    assign BrPC    = exMem.pc;
    assign BrAddr  = {exMem.aluOut[31:2], 2'b00};
    assign BrWData = exMem.ctrl.byteStore ? {4{storeData[7:0]}} : storeData;

    always_comb begin
        if (!exMem.ctrl.memWrite) begin
            BrWE = 4'b0000;
        end else if (exMem.ctrl.byteStore) begin
            BrWE = 4'b0001 << lane;
        end else begin
            BrWE = 4'b1111;
        end
    end

    always_ff @(posedge clk) begin
        loadWord <= BrRData;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wbReg <= '0;
        end else begin
            wbReg.pc       <= exMem.pc;
            wbReg.regWrite <= exMem.ctrl.regWrite;
            wbReg.dest     <= exMem.ctrl.dest;
            wbReg.result   <= exMem.aluOut;
            wbReg.fromLoad <= exMem.ctrl.memRead;
        end
    end

    assign wbValue = wbReg.fromLoad ? loadWord : wbReg.result;

    // Forwarding view carries the final writeback value
    always_comb begin
        memWb        = wbReg;
        memWb.result = wbValue;
    end

    assign regWe    = wbReg.regWrite && (wbReg.dest != '0);
    assign regWAddr = wbReg.dest;
    assign regWData = wbValue;

endmodule

/* hazardUnit.sv */
// Hazard unit
// Compares the decode stage's operand use times against the
// result-ready times of execute and memory, stalling when late
module hazardUnit import cpuPkg::*; (
    input  regAddr_t rsIdx,
    input  regAddr_t rtIdx,
    input  tnew_t    rsUse,
    input  tnew_t    rtUse,
    input  idEx_t    idEx,
    input  exMem_t   exMem,
    output logic     stallFetch,
    output logic     bubbleExecute
);

    logic stall;

    function automatic logic tooLate(regAddr_t src, tnew_t useTime,
                                     regAddr_t dst, tnew_t tnew);
        return (src != '0) && (src == dst) && (tnew > useTime);
    endfunction

    always_comb begin
        stall = tooLate(rsIdx, rsUse, idEx.ctrl.dest, idEx.tnew)
             || tooLate(rsIdx, rsUse, exMem.ctrl.dest, exMem.tnew)
             || tooLate(rtIdx, rtUse, idEx.ctrl.dest, idEx.tnew)
             || tooLate(rtIdx, rtUse, exMem.ctrl.dest, exMem.tnew);
    end

    // Hold fetch and decode, insert a bubble behind them
    assign stallFetch    = stall;
    assign bubbleExecute = stall;

endmodule

/* cpu.sv */
// CPU top
// Five-stage pipelined integer core with external instruction
// fetch and a single-cycle data bus towards the bridge
module cpu import cpuPkg::*; (
    input  logic       clk,
    input  logic       arstN,
    input  word_t      instr,
    input  word_t      BrRData,
    output word_t      instrAddr,
    output word_t      BrPC,
    output word_t      BrAddr,
    output word_t      BrWData,
    output logic [3:0] BrWE
);

    word_t    fetchedInstr;
    word_t    fetchedPc;
    logic     branchTaken;
    word_t    branchTarget;
    regAddr_t raddr1;
    regAddr_t raddr2;
    word_t    rdata1;
    word_t    rdata2;
    regAddr_t rsIdx;
    regAddr_t rtIdx;
    tnew_t    rsUse;
    tnew_t    rtUse;
    logic     stallFetch;
    logic     bubbleExecute;
    idEx_t    idEx;
    exMem_t   exMem;
    memWb_t   memWb;
    logic     regWe;
    regAddr_t regWAddr;
    word_t    regWData;

    fetchStage fetch_i (
        .clk(clk), .arstN(arstN), .instr(instr), .stallFetch(stallFetch),
        .branchTaken(branchTaken), .branchTarget(branchTarget),
        .instrAddr(instrAddr), .fetchedInstr(fetchedInstr), .fetchedPc(fetchedPc)
    );

    decodeStage decode_i (
        .clk(clk), .arstN(arstN), .fetchedInstr(fetchedInstr), .fetchedPc(fetchedPc),
        .bubbleExecute(bubbleExecute), .rdata1(rdata1), .rdata2(rdata2),
        .exMem(exMem), .memWb(memWb), .raddr1(raddr1), .raddr2(raddr2),
        .rsIdx(rsIdx), .rtIdx(rtIdx), .rsUse(rsUse), .rtUse(rtUse),
        .branchTaken(branchTaken), .branchTarget(branchTarget), .idEx(idEx)
    );

    regFile regFile_i (
        .clk(clk), .arstN(arstN), .raddr1(raddr1), .raddr2(raddr2),
        .we(regWe), .waddr(regWAddr), .wdata(regWData),
        .rdata1(rdata1), .rdata2(rdata2)
    );

    executeStage execute_i (
        .clk(clk), .arstN(arstN), .idEx(idEx), .memWb(memWb), .exMem(exMem)
    );

    memStage mem_i (
        .clk(clk), .arstN(arstN), .exMem(exMem), .BrRData(BrRData),
        .BrPC(BrPC), .BrAddr(BrAddr), .BrWData(BrWData), .BrWE(BrWE),
        .memWb(memWb), .regWe(regWe), .regWAddr(regWAddr), .regWData(regWData)
    );

    hazardUnit hazard_i (
        .rsIdx(rsIdx), .rtIdx(rtIdx), .rsUse(rsUse), .rtUse(rtUse),
        .idEx(idEx), .exMem(exMem),
        .stallFetch(stallFetch), .bubbleExecute(bubbleExecute)
    );

endmodule

/* cpu_chk.sv */
// CPU bus and pipeline checker
// Concurrent assertions on the data bus strobes, address
// alignment and the stall/bubble pairing, bound into the core
module cpuChk import cpuPkg::*; (
    input logic       clk,
    input logic       arstN,
    input logic [3:0] BrWE,
    input logic [31:0] BrAddr,
    input logic       stallFetch,
    input logic       bubbleExecute,
    input word_t      instrAddr,
    input idEx_t      idEx
);

    timeunit 1ns;
    timeprecision 100ps;

    // No stores while in reset
    weInReset: assert property (@(posedge clk) !arstN |-> BrWE == 4'b0000)
        else $error("BrWE active during reset");

    weLegal: assert property (@(posedge clk) disable iff (!arstN)
        BrWE == 4'b0000 || BrWE == 4'b1111 || $onehot(BrWE))
        else $error("BrWE is neither idle, full word nor a single lane");

    addrAligned: assert property (@(posedge clk) disable iff (!arstN)
        BrAddr[1:0] == 2'b00)
        else $error("BrAddr is not word aligned");

    // A stall freezes fetch and sends a bubble into execute together
    stallPaired: assert property (@(posedge clk) disable iff (!arstN)
        (stallFetch || bubbleExecute) |=> $stable(instrAddr) && idEx.ctrl == '0)
        else $error("Stall did not hold fetch together with a bubble into execute");

endmodule

bind cpu cpuChk chk_i (
    .clk(clk), .arstN(arstN), .BrWE(BrWE), .BrAddr(BrAddr),
    .stallFetch(stallFetch), .bubbleExecute(bubbleExecute),
    .instrAddr(instrAddr), .idEx(idEx)
);

/* cpu_tb.sv */
// CPU testbench
// Runs a program from the stimulus file on the core with an
// instruction ROM and a byte-writable data RAM, and checks every
// bus store in order against the expected stores
`include "cpu_cfg.svh"

module cpu_tb import cpuPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int romWords      = 256;
    localparam int ramWords      = 256;
    localparam int maxStores     = 32;
    localparam int timeoutCycles = 2000;
    localparam int drainCycles   = 20;

    logic       clk;
    logic       arstN;
    word_t      instr;
    word_t      BrRData;
    word_t      instrAddr;
    word_t      BrPC;
    word_t      BrAddr;
    word_t      BrWData;
    logic [3:0] BrWE;
    word_t      romOffset;

    word_t      rom [romWords];
    word_t      ram [ramWords];
    string      expName [maxStores];
    word_t      expAddr [maxStores];
    word_t      expData [maxStores];
    logic [3:0] expBe [maxStores];
    word_t      expPc [maxStores];

    int numExp;
    int storeIdx;
    int passCount;
    int failCount;
    int errorCount;

    cpu dut_i (
        .clk(clk), .arstN(arstN), .instr(instr), .BrRData(BrRData),
        .instrAddr(instrAddr), .BrPC(BrPC), .BrAddr(BrAddr),
        .BrWData(BrWData), .BrWE(BrWE)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // Instruction ROM, nop outside the program
    always_comb begin
        romOffset = instrAddr - `CPU_RESET_PC;
        if (romOffset[31:10] == '0) begin
            instr = rom[romOffset[9:2]];
        end else begin
            instr = '0;
        end
    end

    always_comb begin
        if (BrAddr[31:10] == '0) begin
            BrRData = ram[BrAddr[9:2]];
        end else begin
            BrRData = '0;
        end
    end

    // Byte-lane writes into the data RAM
    always @(posedge clk) begin
        if (arstN && BrWE != 4'b0000 && BrAddr[31:10] == '0) begin
            for (int b = 0; b < 4; b++) begin
                if (BrWE[b]) begin
                    ram[BrAddr[9:2]][8*b +: 8] <= BrWData[8*b +: 8];
                end
            end
        end
    end

    task automatic loadStimulus(output bit ok);
        int fd;
        int code;
        int romIdx;
        string tag;
        string name;
        word_t word;
        word_t addr;
        logic [3:0] be;
        logic [8*160-1:0] lineBuf;
        ok = 1'b1;
        romIdx = 0;
        fd = $fopen("cpu_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file cpu_stimulus.txt");
            ok = 1'b0;
            return;
        end
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag.getc(0) == "#") begin
                code = $fgets(lineBuf, fd);
            end else if (tag == "I") begin
                code = $fscanf(fd, "%h", word);
                if (romIdx < romWords) begin
                    rom[romIdx] = word;
                end
                romIdx++;
            end else if (tag == "D") begin
                code = $fscanf(fd, "%h %h", addr, word);
                ram[addr[9:2]] = word;
            end else if (tag == "E") begin
                code = $fscanf(fd, "%s %h %h %h", name, addr, word, be);
                if (numExp < maxStores) begin
                    expName[numExp] = name;
                    expAddr[numExp] = addr;
                    expData[numExp] = word;
                    expBe[numExp]   = be;
                    numExp++;
                end
            end else begin
                $display("Unknown line type %s in the stimulus file", tag);
                ok = 1'b0;
            end
        end
        $fclose(fd);
        if (numExp == 0) begin
            $display("The stimulus file holds no expected stores");
            ok = 1'b0;
        end
    endtask

    // Stores reach the bus in program order, none sits on a skipped path
    task automatic findStorePcs();
        int n;
        logic [5:0] opcode;
        n = 0;
        for (int k = 0; k < maxStores; k++) begin
            expPc[k] = '0;
        end
        for (int i = 0; i < romWords; i++) begin
            opcode = rom[i][31:26];
            if ((opcode == 6'b101011 || opcode == 6'b101000) && n < maxStores) begin
                expPc[n] = `CPU_RESET_PC + 4 * i;
                n++;
            end
        end
    endtask

    task automatic checkStore();
        bit good;
        good = 1'b1;
        if (storeIdx >= numExp) begin
            $display("Unexpected extra store to %h with data %h and byte enables %b",
                     BrAddr, BrWData, BrWE);
            errorCount++;
        end else begin
            if (BrAddr != expAddr[storeIdx]) begin
                $display("Mismatch %s address: expected %h actual %h",
                         expName[storeIdx], expAddr[storeIdx], BrAddr);
                good = 1'b0;
            end
            if (BrWData != expData[storeIdx]) begin
                $display("Mismatch %s data: expected %h actual %h",
                         expName[storeIdx], expData[storeIdx], BrWData);
                good = 1'b0;
            end
            if (BrWE != expBe[storeIdx]) begin
                $display("Mismatch %s byte enables: expected %b actual %b",
                         expName[storeIdx], expBe[storeIdx], BrWE);
                good = 1'b0;
            end
            if (BrPC != expPc[storeIdx]) begin
                $display("Mismatch %s pc: expected %h actual %h",
                         expName[storeIdx], expPc[storeIdx], BrPC);
                good = 1'b0;
            end
            if (good) begin
                passCount++;
                $display("Test %s passed", expName[storeIdx]);
            end else begin
                failCount++;
                $display("Test %s failed", expName[storeIdx]);
            end
            storeIdx++;
        end
    endtask

    // Bus outputs settle well before the falling edge
    always @(negedge clk) begin
        if (arstN && BrWE != 4'b0000) begin
            checkStore();
        end
    end

    initial begin
        bit loadOk;
        bit timedOut;
        int cycles;
        arstN      = 1'b0;
        numExp     = 0;
        storeIdx   = 0;
        passCount  = 0;
        failCount  = 0;
        errorCount = 0;
        timedOut   = 1'b0;
        for (int i = 0; i < romWords; i++) begin
            rom[i] = '0;
        end
        for (int i = 0; i < ramWords; i++) begin
            ram[i] = '0;
        end
        loadStimulus(loadOk);
        findStorePcs();
        repeat (5) @(posedge clk);
        #1 arstN = 1'b1;
        if (loadOk) begin
            cycles = 0;
            while (storeIdx < numExp && cycles < timeoutCycles) begin
                @(posedge clk);
                cycles++;
            end
            if (storeIdx < numExp) begin
                timedOut = 1'b1;
                $display("Timeout: store %s never appeared on the bus", expName[storeIdx]);
            end else begin
                // Catch stray stores after the last one
                cycles = 0;
                while (cycles < drainCycles) begin
                    @(posedge clk);
                    cycles++;
                end
            end
        end
        $display("Tests passed %0d, failed %0d, other errors %0d",
                 passCount, failCount, errorCount);
        if (loadOk && !timedOut && failCount == 0 && errorCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* cpu_stimulus.txt */
# I word | D addr word | E name addr data byteEnables (all hex)
# Program words start at the reset PC, one per I line
D 00000000 00001234
D 00000004 00000005
I 34010010
I 3c021234
I 00411821
I 00612023
I 348500ff
I ac050040
I ac030044
I 8c060000
I 00c13821
I ac070048
I 340800a5
I a0080050
I a0080051
I a0080052
I a0080053
I 8c090050
I ac090054
I 8c0b0004
I 340a0005
I 114b0002
I 340c0011
I 340c00ee
I ac0c0058
I 8c0d0000
I 340e1235
I 11ae0002
I 340f0022
I 35ef0100
I ac0f005c
I 34007777
I 00220021
I ac000060
E aluChain 00000040 123400ff f
E aluAddu 00000044 12340010 f
E loadUse 00000048 00001244 f
E byteLane0 00000050 a5a5a5a5 1
E byteLane1 00000050 a5a5a5a5 2
E byteLane2 00000050 a5a5a5a5 4
E byteLane3 00000050 a5a5a5a5 8
E byteReload 00000054 a5a5a5a5 f
E branchTaken 00000058 00000011 f
E branchNotTaken 0000005c 00000122 f
E regZero 00000060 00000000 f

/* src.f */
+incdir+.
cpuPkg.sv
fetchStage.sv
decodeStage.sv
regFile.sv
executeStage.sv
memStage.sv
hazardUnit.sv
cpu.sv
cpu_chk.sv
cpu_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the CPU testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f src.f --top-module cpu_tb -o cpu_sim || exit 1
out=$(./obj_dir/cpu_sim 2>&1)
echo "$out"
echo "$out" | grep -q "^PASS: all tests$" && exit 0 || exit 1
